/* verilog/dcache_defs.svh */
// L1 data cache geometry
// Ways, line size and set count, plus the address field widths derived from them

`ifndef DCACHE_DEFS_SVH
`define DCACHE_DEFS_SVH

// Number of ways
`define DCACHE_WAYS 2

// 32-bit words per line
`define DCACHE_LINE_WORDS 4

// log2 of the number of sets
`define DCACHE_SETS_LOG2 4

// Word select field inside a line
`define DCACHE_WORD_SEL_W $clog2(`DCACHE_LINE_WORDS)

// Tag is what is left of the 30-bit word address
`define DCACHE_TAG_W (30 - `DCACHE_SETS_LOG2 - `DCACHE_WORD_SEL_W)

`endif

/* verilog/dcache_pkg.sv */
// L1 data cache types
// Request kinds, fill FSM states and the address field types

`include "dcache_defs.svh"

package dcache_pkg;

    // Core request kind
    typedef enum logic {
        REQ_READ,
        REQ_WRITE
    } req_kind_t;

    // Miss handling FSM
    typedef enum logic [1:0] {
        FILL_IDLE,
        FILL_REQUEST,
        FILL_RETURN
    } fill_state_t;

    // Address fields, byte offset in bits 1:0 then word, set and tag
    typedef logic [`DCACHE_SETS_LOG2-1:0]  set_t;
    typedef logic [`DCACHE_WORD_SEL_W-1:0] word_sel_t;
    typedef logic [`DCACHE_TAG_W-1:0]      tag_t;

    // One bit per way, for hit and replacement masks
    typedef logic [`DCACHE_WAYS-1:0] way_mask_t;

endpackage

/* verilog/dcache_tagbank.sv */
// Tag array of the L1 data cache
// Valid bit and tag per way per set, with lookup, fill writes,
// snoop invalidation and the clearing sweep after reset

`include "dcache_defs.svh"

module dcache_tagbank (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  lookup_en,
    input  dcache_pkg::set_t      lookup_set,
    input  dcache_pkg::tag_t      lookup_tag,
    input  logic                  fill_write,
    input  dcache_pkg::set_t      fill_set,
    input  dcache_pkg::tag_t      fill_tag,
    input  dcache_pkg::way_mask_t fill_way,
    input  logic                  inv,
    input  logic [31:0]           inv_addr,
    output dcache_pkg::way_mask_t hit_mask,
    output logic                  busy
);
    import dcache_pkg::*;

    localparam int SETS    = 1 << `DCACHE_SETS_LOG2;
    localparam int SET_LSB = 2 + `DCACHE_WORD_SEL_W;
    localparam int TAG_LSB = SET_LSB + `DCACHE_SETS_LOG2;

    way_mask_t valid_mem [SETS];
    tag_t      tag_mem   [SETS][`DCACHE_WAYS];

    logic sweep_done;
    set_t sweep_set;

    set_t      inv_set;
    tag_t      inv_tag;
    logic      snoop_rd;
    set_t      snoop_set_r;
    tag_t      snoop_tag_r;
    way_mask_t snoop_valid_r;
    tag_t      snoop_tags_r [`DCACHE_WAYS];
    way_mask_t snoop_hit;
    logic      snoop_write;
    logic      fill_valid;

    tag_t      lookup_tag_r;
    way_mask_t lookup_valid_r;
    tag_t      lookup_tags_r [`DCACHE_WAYS];

    ////////////////////
    // Reset sweep, one set per cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            sweep_done <= 1'b0;
            sweep_set  <= '0;
        end else if (!sweep_done) begin
            {sweep_done, sweep_set} <= {1'b0, sweep_set} + 1'b1;
        end
    end

    ////////////////////
    // Snoop read on port B, write back on port A next cycle
    assign inv_set = inv_addr[SET_LSB +: `DCACHE_SETS_LOG2];
    assign inv_tag = inv_addr[31:TAG_LSB];

    always_ff @(posedge clk) begin
        if (rst) begin
            snoop_rd <= 1'b0;
        end else begin
            snoop_rd <= inv & sweep_done;
        end
        snoop_set_r   <= inv_set;
        snoop_tag_r   <= inv_tag;
        snoop_valid_r <= valid_mem[inv_set];
        snoop_tags_r  <= tag_mem[inv_set];
    end

    always_comb begin
        for (int w = 0; w < `DCACHE_WAYS; w++) begin
            snoop_hit[w] = snoop_valid_r[w] & (snoop_tags_r[w] == snoop_tag_r);
        end
    end

    assign snoop_write = snoop_rd & |snoop_hit;

    // A line snooped while its tag is written goes in invalid
    assign fill_valid = ~(inv & (inv_set == fill_set) & (inv_tag == fill_tag));

    ////////////////////
    // Array writes and lookup read
    always_ff @(posedge clk) begin
        for (int w = 0; w < `DCACHE_WAYS; w++) begin
            if (!sweep_done) begin
                valid_mem[sweep_set][w] <= 1'b0;
            end
            if (fill_write && fill_way[w]) begin
                valid_mem[fill_set][w] <= fill_valid;
                tag_mem[fill_set][w]   <= fill_tag;
            end
            // Snoop clear comes last so it wins on the same entry
            if (snoop_write && snoop_hit[w]) begin
                valid_mem[snoop_set_r][w] <= 1'b0;
            end
        end
        if (lookup_en) begin
            lookup_valid_r <= valid_mem[lookup_set];
            lookup_tags_r  <= tag_mem[lookup_set];
            lookup_tag_r   <= lookup_tag;
        end
    end

    always_comb begin
        for (int w = 0; w < `DCACHE_WAYS; w++) begin
            hit_mask[w] = lookup_valid_r[w] & (lookup_tags_r[w] == lookup_tag_r);
        end
    end

    // No new lookup while sweeping or while a snoop owns port A
    assign busy = ~sweep_done | snoop_write;

endmodule

/* verilog/dcache_databank.sv */
// Data array of the L1 data cache
// One word per way, set and word position with byte write enables;
// all ways are read together and the hit way is picked afterwards

`include "dcache_defs.svh"

module dcache_databank (
    input  logic                  clk,
    input  logic                  rd_en,
    input  dcache_pkg::set_t      rd_set,
    input  dcache_pkg::word_sel_t rd_word,
    input  dcache_pkg::way_mask_t hit_mask,
    input  logic                  wr_en,
    input  dcache_pkg::way_mask_t wr_way,
    input  dcache_pkg::set_t      wr_set,
    input  dcache_pkg::word_sel_t wr_word,
    input  logic [31:0]           wr_data,
    input  logic [3:0]            wr_be,
    output logic [31:0]           rd_data
);
    localparam int ADDR_W = `DCACHE_SETS_LOG2 + `DCACHE_WORD_SEL_W;
    localparam int DEPTH  = 1 << ADDR_W;

    logic [3:0][7:0] data_mem [`DCACHE_WAYS][DEPTH];
    logic [31:0]     rd_words [`DCACHE_WAYS];
    logic [ADDR_W-1:0] rd_index;
    logic [ADDR_W-1:0] wr_index;

    assign rd_index = {rd_set, rd_word};
    assign wr_index = {wr_set, wr_word};

    always_ff @(posedge clk) begin
        for (int w = 0; w < `DCACHE_WAYS; w++) begin
            for (int b = 0; b < 4; b++) begin
                if (wr_en && wr_way[w] && wr_be[b]) begin
                    data_mem[w][wr_index][b] <= wr_data[8*b +: 8];
                end
            end
            if (rd_en) begin
                rd_words[w] <= data_mem[w][rd_index];
            end
        end
    end

    // hit_mask is one-hot or empty, so an OR picks the way
    always_comb begin
        rd_data = '0;
        for (int w = 0; w < `DCACHE_WAYS; w++) begin
            if (hit_mask[w]) begin
                rd_data = rd_data | rd_words[w];
            end
        end
    end

endmodule

/* verilog/dcache_controller.sv */
// Request controller of the L1 data cache
// Stage 1 request handling, line fill on read misses, write-through
// to memory and random replacement

`include "dcache_defs.svh"

module dcache_controller (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  req_valid,
    output logic                  req_ready,
    input  dcache_pkg::req_kind_t req_kind,
    input  logic [31:0]           req_addr,
    input  logic [31:0]           req_wdata,
    input  logic [3:0]            req_be,
    output logic                  resp_valid,
    output logic [31:0]           resp_data,
    output logic                  mem_req_valid,
    input  logic                  mem_req_ready,
    output logic                  mem_rnw,
    output logic [29:0]           mem_addr,
    output logic [31:0]           mem_wdata,
    output logic [3:0]            mem_wbe,
    output logic [4:0]            mem_rlen,
    input  logic                  mem_rvalid,
    input  logic [31:0]           mem_rdata,
    output logic                  lookup_en,
    output dcache_pkg::set_t      lookup_set,
    output dcache_pkg::tag_t      lookup_tag,
    output logic                  fill_write,
    output dcache_pkg::set_t      fill_set,
    output dcache_pkg::tag_t      fill_tag,
    output dcache_pkg::way_mask_t fill_way,
    input  dcache_pkg::way_mask_t hit_mask,
    input  logic                  tag_busy,
    output logic                  db_rd_en,
    output dcache_pkg::set_t      db_rd_set,
    output dcache_pkg::word_sel_t db_rd_word,
    input  logic [31:0]           db_rd_data,
    output logic                  db_wr_en,
    output dcache_pkg::way_mask_t db_wr_way,
    output dcache_pkg::set_t      db_wr_set,
    output dcache_pkg::word_sel_t db_wr_word,
    output logic [31:0]           db_wr_data,
    output logic [3:0]            db_wr_be
);
    import dcache_pkg::*;

    localparam int WS      = `DCACHE_WORD_SEL_W;
    localparam int SET_LSB = 2 + WS;
    localparam int TAG_LSB = SET_LSB + `DCACHE_SETS_LOG2;

    logic        accept;
    logic        s1_valid;
    logic        s1_first;
    req_kind_t   s1_kind;
    logic [31:0] s1_addr;
    logic [31:0] s1_wdata;
    logic [3:0]  s1_be;
    set_t        s1_set;
    word_sel_t   s1_word;
    logic        s1_read;
    logic        s1_hit;
    logic        s1_done;

    fill_state_t fill_state;
    fill_state_t fill_next;
    logic        fill_ack_r;
    word_sel_t   word_count;
    logic        last_word;
    logic        correct_word;
    logic        wr_hit;
    logic        wr_fill;
    way_mask_t   repl_way;

    ////////////////////
    // Stage 0, lookup issued on the accepting edge
    assign accept     = req_valid & req_ready;
    assign lookup_en  = accept;
    assign lookup_set = req_addr[SET_LSB +: `DCACHE_SETS_LOG2];
    assign lookup_tag = req_addr[31:TAG_LSB];
    assign db_rd_en   = accept;
    assign db_rd_set  = req_addr[SET_LSB +: `DCACHE_SETS_LOG2];
    assign db_rd_word = req_addr[2 +: WS];

    // A databank write blocks entry so a read behind it sees the new word
    assign req_ready = ~tag_busy & (~s1_valid | s1_done) & ~db_wr_en;

    ////////////////////
    // Stage 1 request register
    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid <= 1'b0;
            s1_first <= 1'b0;
        end else begin
            s1_first <= accept;
            if (accept) begin
                s1_valid <= 1'b1;
            end else if (s1_done) begin
                s1_valid <= 1'b0;
            end
        end
        if (accept) begin
            s1_kind  <= req_kind;
            s1_addr  <= req_addr;
            s1_wdata <= req_wdata;
            s1_be    <= req_be;
        end
    end

    assign s1_set  = s1_addr[SET_LSB +: `DCACHE_SETS_LOG2];
    assign s1_word = s1_addr[2 +: WS];
    assign s1_read = (s1_kind == REQ_READ);
    // Tag result is only valid in the first stage 1 cycle
    assign s1_hit  = |hit_mask;

    // Hits end at once, misses on the last burst word, writes on the memory ack
    assign s1_done = s1_valid & (s1_read ? (s1_first ? s1_hit : last_word) : mem_req_ready);

    ////////////////////
    // Fill FSM
    always_comb begin
        fill_next = fill_state;
        unique case (fill_state)
            FILL_IDLE: begin
                if (s1_first && s1_read && !s1_hit) begin
                    fill_next = FILL_REQUEST;
                end
            end
            FILL_REQUEST: begin
                if (mem_req_ready) begin
                    fill_next = FILL_RETURN;
                end
            end
            FILL_RETURN: begin
                if (last_word) begin
                    fill_next = FILL_IDLE;
                end
            end
            default: fill_next = FILL_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            fill_state <= FILL_IDLE;
            fill_ack_r <= 1'b0;
        end else begin
            fill_state <= fill_next;
            fill_ack_r <= (fill_state == FILL_REQUEST) & mem_req_ready;
        end
    end

    // Burst words arrive in line order from word 0
    always_ff @(posedge clk) begin
        if (rst || s1_done) begin
            word_count <= '0;
        end else if (mem_rvalid) begin
            word_count <= word_count + 1'b1;
        end
    end

    assign wr_fill      = (fill_state == FILL_RETURN) & mem_rvalid;
    assign last_word    = wr_fill & (word_count == word_sel_t'(`DCACHE_LINE_WORDS - 1));
    assign correct_word = wr_fill & (word_count == s1_word);

    // Rotating one-hot victim pointer
    always_ff @(posedge clk) begin
        if (rst) begin
            repl_way <= way_mask_t'(1);
        end else if (accept) begin
            repl_way <= way_mask_t'({repl_way, repl_way[`DCACHE_WAYS-1]});
        end
    end

    ////////////////////
    // Tag write one cycle after the read ack
    assign fill_write = fill_ack_r;
    assign fill_set   = s1_set;
    assign fill_tag   = s1_addr[31:TAG_LSB];
    assign fill_way   = repl_way;

    // Databank takes fill words, or write data on a write hit
    assign wr_hit     = s1_first & ~s1_read & s1_hit;
    assign db_wr_en   = wr_hit | wr_fill;
    assign db_wr_way  = wr_fill ? repl_way : hit_mask;
    assign db_wr_set  = s1_set;
    assign db_wr_word = wr_fill ? word_count : s1_word;
    assign db_wr_data = wr_fill ? mem_rdata : s1_wdata;
    assign db_wr_be   = wr_fill ? 4'hf : s1_be;

    ////////////////////
    // Memory request, held from stage 1 until mem_req_ready
    assign mem_req_valid = (fill_state == FILL_REQUEST) | (s1_valid & ~s1_read);
    assign mem_rnw       = s1_read;
    assign mem_addr      = s1_read ? {s1_addr[31:SET_LSB], {WS{1'b0}}} : s1_addr[31:2];
    assign mem_wdata     = s1_wdata;
    assign mem_wbe       = s1_be;
    assign mem_rlen      = s1_read ? 5'(`DCACHE_LINE_WORDS - 1) : 5'd0;

    // Core response for reads only
    assign resp_valid = s1_valid & s1_read & (s1_first ? s1_hit : correct_word);
    assign resp_data  = s1_first ? db_rd_data : mem_rdata;

endmodule

/* verilog/dcache_top.sv */
// L1 data cache, write-through and set-associative
// Connects the request controller to the tag and data arrays

module dcache_top (
    input  logic                  clk,
    input  logic                  rst,

    // Core request
    input  logic                  req_valid,
    output logic                  req_ready,
    input  dcache_pkg::req_kind_t req_kind,
    input  logic [31:0]           req_addr,
    input  logic [31:0]           req_wdata,
    input  logic [3:0]            req_be,

    // Core response
    output logic                  resp_valid,
    output logic [31:0]           resp_data,

    // Memory request and burst return
    output logic                  mem_req_valid,
    input  logic                  mem_req_ready,
    output logic                  mem_rnw,
    output logic [29:0]           mem_addr,
    output logic [31:0]           mem_wdata,
    output logic [3:0]            mem_wbe,
    output logic [4:0]            mem_rlen,
    input  logic                  mem_rvalid,
    input  logic [31:0]           mem_rdata,

    // Snoop invalidation
    input  logic                  inv,
    input  logic [31:0]           inv_addr
);
    import dcache_pkg::*;

    // Controller to tagbank
    logic      lookup_en;
    set_t      lookup_set;
    tag_t      lookup_tag;
    logic      fill_write;
    set_t      fill_set;
    tag_t      fill_tag;
    way_mask_t fill_way;
    way_mask_t hit_mask;
    logic      tag_busy;

    // Controller to databank
    logic        db_rd_en;
    set_t        db_rd_set;
    word_sel_t   db_rd_word;
    logic [31:0] db_rd_data;
    logic        db_wr_en;
    way_mask_t   db_wr_way;
    set_t        db_wr_set;
    word_sel_t   db_wr_word;
    logic [31:0] db_wr_data;
    logic [3:0]  db_wr_be;

    dcache_controller u_controller (
        .clk, .rst,
        .req_valid, .req_ready, .req_kind, .req_addr, .req_wdata, .req_be,
        .resp_valid, .resp_data,
        .mem_req_valid, .mem_req_ready, .mem_rnw, .mem_addr, .mem_wdata, .mem_wbe,
        .mem_rlen, .mem_rvalid, .mem_rdata,
        .lookup_en, .lookup_set, .lookup_tag,
        .fill_write, .fill_set, .fill_tag, .fill_way,
        .hit_mask, .tag_busy,
        .db_rd_en, .db_rd_set, .db_rd_word, .db_rd_data,
        .db_wr_en, .db_wr_way, .db_wr_set, .db_wr_word, .db_wr_data, .db_wr_be
    );

    dcache_tagbank u_tagbank (
        .clk, .rst,
        .lookup_en, .lookup_set, .lookup_tag,
        .fill_write, .fill_set, .fill_tag, .fill_way,
        .inv, .inv_addr,
        .hit_mask,
        .busy (tag_busy)
    );

    dcache_databank u_databank (
        .clk,
        .rd_en   (db_rd_en),
        .rd_set  (db_rd_set),
        .rd_word (db_rd_word),
        .hit_mask,
        .wr_en   (db_wr_en),
        .wr_way  (db_wr_way),
        .wr_set  (db_wr_set),
        .wr_word (db_wr_word),
        .wr_data (db_wr_data),
        .wr_be   (db_wr_be),
        .rd_data (db_rd_data)
    );

endmodule

/* sim/dcache_checker.sv */
// Assertions for the L1 data cache
// Bound into the DUT, compares responses with the testbench memory model
// and checks the core and memory handshakes

`include "dcache_defs.svh"

module dcache_checker (
    input logic                  clk,
    input logic                  rst,
    input logic                  req_valid,
    input logic                  req_ready,
    input dcache_pkg::req_kind_t req_kind,
    input logic [31:0]           req_addr,
    input logic [31:0]           req_wdata,
    input logic [3:0]            req_be,
    input logic                  resp_valid,
    input logic [31:0]           resp_data,
    input logic                  mem_req_valid,
    input logic                  mem_req_ready,
    input logic                  mem_rnw,
    input logic [29:0]           mem_addr,
    input logic [31:0]           mem_wdata,
    input logic [3:0]            mem_wbe,
    input logic [4:0]            mem_rlen,
    input logic [31:0]           exp_rdata,
    input logic                  expect_hit,
    input logic                  expect_miss
);
    timeunit 1ns;
    timeprecision 1ps;
    import dcache_pkg::*;

    localparam int SWEEP_CYCLES = 1 << `DCACHE_SETS_LOG2;
    localparam int LINE_LSB     = 2 + `DCACHE_WORD_SEL_W;

    int unsigned error_count = 0;
    int unsigned run_cycles;
    logic        read_pending;
    logic        write_pending;
    logic        line_fetched;
    logic [31:0] acc_addr;
    logic [31:0] acc_wdata;
    logic [3:0]  acc_be;
    logic [29:0] line_addr;
    logic [65:0] write_fields;

    ////////////////////
    // Request currently in the cache
    always_ff @(posedge clk) begin
        if (rst) begin
            run_cycles    <= 0;
            read_pending  <= 1'b0;
            write_pending <= 1'b0;
            line_fetched  <= 1'b0;
        end else begin
            if (run_cycles < SWEEP_CYCLES) begin
                run_cycles <= run_cycles + 1;
            end
            if (resp_valid) begin
                read_pending <= 1'b0;
            end
            if (mem_req_valid && mem_req_ready) begin
                line_fetched  <= line_fetched | mem_rnw;
                write_pending <= write_pending & mem_rnw;
            end
            if (req_valid && req_ready) begin
                read_pending  <= (req_kind == REQ_READ);
                write_pending <= (req_kind == REQ_WRITE);
                line_fetched  <= 1'b0;
            end
        end
        if (req_valid && req_ready) begin
            acc_addr  <= req_addr;
            acc_wdata <= req_wdata;
            acc_be    <= req_be;
        end
    end

    assign line_addr    = {acc_addr[31:LINE_LSB], {`DCACHE_WORD_SEL_W{1'b0}}};
    assign write_fields = {acc_addr[31:2], acc_wdata, acc_be};

    ////////////////////
    // Reset and tag sweep
    a_reset_quiet: assert property (@(posedge clk)
        $fell(rst) |-> !req_ready && !resp_valid && !mem_req_valid)
        else begin
            error_count++;
            $error("core or memory outputs active as reset ends");
        end

    a_sweep: assert property (@(posedge clk) disable iff (rst)
        run_cycles < SWEEP_CYCLES |-> !req_ready)
        else begin
            error_count++;
            $error("req_ready rose before the tag sweep could finish");
        end

    ////////////////////
    // Core responses
    a_resp_pending: assert property (@(posedge clk) disable iff (rst)
        resp_valid |-> read_pending)
        else begin
            error_count++;
            $error("response given without an outstanding read");
        end

    a_resp_data: assert property (@(posedge clk) disable iff (rst)
        resp_valid |-> resp_data == exp_rdata)
        else begin
            error_count++;
            $error("[ERROR] %0t resp_data got %h expected %h",
                $time, $sampled(resp_data), $sampled(exp_rdata));
        end

    a_hit: assert property (@(posedge clk) disable iff (rst)
        req_valid && req_ready && req_kind == REQ_READ && expect_hit
        |=> resp_valid && !mem_req_valid)
        else begin
            error_count++;
            $error("read of a cached line not answered in the next cycle");
        end

    a_miss: assert property (@(posedge clk) disable iff (rst)
        req_valid && req_ready && req_kind == REQ_READ && expect_miss |=> !resp_valid)
        else begin
            error_count++;
            $error("read of a snooped line answered from the cache");
        end

    ////////////////////
    // Memory requests
    a_fetch_once: assert property (@(posedge clk) disable iff (rst)
        mem_req_valid && mem_rnw |-> read_pending && !line_fetched)
        else begin
            error_count++;
            $error("memory read without a pending read miss");
        end

    a_fetch_line: assert property (@(posedge clk) disable iff (rst)
        mem_req_valid && mem_rnw
        |-> {mem_addr, mem_rlen} == {line_addr, 5'(`DCACHE_LINE_WORDS - 1)})
        else begin
            error_count++;
            $error("[ERROR] %0t {mem_addr,mem_rlen} got %h expected %h", $time,
                $sampled({mem_addr, mem_rlen}),
                $sampled({line_addr, 5'(`DCACHE_LINE_WORDS - 1)}));
        end

    a_write_fields: assert property (@(posedge clk) disable iff (rst)
        mem_req_valid && !mem_rnw
        |-> write_pending && {mem_addr, mem_wdata, mem_wbe} == write_fields)
        else begin
            error_count++;
            $error("[ERROR] %0t {mem_addr,mem_wdata,mem_wbe} got %h expected %h", $time,
                $sampled({mem_addr, mem_wdata, mem_wbe}), $sampled(write_fields));
        end

    a_write_sent: assert property (@(posedge clk) disable iff (rst)
        req_valid && req_ready
        |-> !write_pending || (mem_req_valid && mem_req_ready && !mem_rnw))
        else begin
            error_count++;
            $error("new request accepted before the write went to memory");
        end

    a_stable: assert property (@(posedge clk) disable iff (rst)
        mem_req_valid && !mem_req_ready
        |=> mem_req_valid && $stable({mem_rnw, mem_addr, mem_wdata, mem_wbe, mem_rlen}))
        else begin
            error_count++;
            $error("memory request dropped or changed before mem_req_ready");
        end

endmodule

/* sim/dcache_tb.sv */
// Testbench for the L1 data cache
// Burst memory model, core requests and snoops; checking is done by the
// bound assertions

`include "dcache_defs.svh"

module dcache_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import dcache_pkg::*;

    localparam int MEM_WORDS  = 256;
    localparam int LINE_LSB   = 2 + `DCACHE_WORD_SEL_W;
    // Directed and random tests need about 1500 cycles
    localparam int MAX_CYCLES = 4000;

    logic        clk;
    logic        rst;
    logic        req_valid;
    logic        req_ready;
    req_kind_t   req_kind;
    logic [31:0] req_addr;
    logic [31:0] req_wdata;
    logic [3:0]  req_be;
    logic        resp_valid;
    logic [31:0] resp_data;
    logic        mem_req_valid;
    logic        mem_req_ready = 1'b0;
    logic        mem_rnw;
    logic [29:0] mem_addr;
    logic [31:0] mem_wdata;
    logic [3:0]  mem_wbe;
    logic [4:0]  mem_rlen;
    logic        mem_rvalid = 1'b0;
    logic [31:0] mem_rdata = '0;
    logic        inv;
    logic [31:0] inv_addr;

    logic [31:0] mem_model [MEM_WORDS];
    integer      seed;
    logic [1:0]  mem_delay;
    logic [7:0]  burst_idx;
    logic [5:0]  burst_left;
    int unsigned cycle_count = 0;

    // Expected values for the checker
    logic        expect_hit = 1'b0;
    logic        expect_miss = 1'b0;
    logic [31:0] rd_addr = '0;
    logic [31:0] exp_rdata;

    assign exp_rdata = mem_model[rd_addr[9:2]];

    dcache_top DUT (.*);

    bind dcache_top dcache_checker u_checker (
        .clk, .rst, .req_valid, .req_ready, .req_kind, .req_addr, .req_wdata, .req_be,
        .resp_valid, .resp_data, .mem_req_valid, .mem_req_ready, .mem_rnw, .mem_addr,
        .mem_wdata, .mem_wbe, .mem_rlen,
        .exp_rdata   (dcache_tb.exp_rdata),
        .expect_hit  (dcache_tb.expect_hit),
        .expect_miss (dcache_tb.expect_miss)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic fail_run(input string why);
        $display("CHECKS FAILED");
        $fatal(1, "%s", why);
    endtask

    // Timeout and first failed assertion
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            fail_run($sformatf("run did not finish within %0d cycles", MAX_CYCLES));
        end else if (DUT.u_checker.error_count != 0) begin
            fail_run("an assertion in the checker failed");
        end
    end

    ////////////////////
    // Memory model that accepts after 0 to 3 cycles and returns from word 0
    always @(posedge clk) begin
        if (rst) begin
            mem_req_ready <= 1'b0;
            mem_rvalid    <= 1'b0;
            burst_left    <= '0;
            mem_delay     <= 2'($random(seed));
        end else begin
            mem_rvalid <= 1'b0;
            if (burst_left != 0) begin
                mem_rvalid <= 1'b1;
                mem_rdata  <= mem_model[burst_idx];
                burst_idx  <= burst_idx + 1'b1;
                burst_left <= burst_left - 1'b1;
            end
            if (mem_req_valid && mem_req_ready) begin
                mem_req_ready <= 1'b0;
                mem_delay     <= 2'($random(seed));
                if (mem_rnw) begin
                    burst_idx  <= mem_addr[7:0];
                    burst_left <= mem_rlen + 1'b1;
                end else begin
                    for (int b = 0; b < 4; b++) begin
                        if (mem_wbe[b]) begin
                            mem_model[mem_addr[7:0]][8*b +: 8] <= mem_wdata[8*b +: 8];
                        end
                    end
                end
            end else if (mem_req_valid && burst_left == 0) begin
                if (mem_delay == 0) begin
                    mem_req_ready <= 1'b1;
                end else begin
                    mem_delay <= mem_delay - 1'b1;
                end
            end
        end
    end

    function automatic logic [31:0] rand_addr();
        return {22'b0, 8'($random(seed)), 2'b00};
    endfunction

    // One core request; a read also waits for its response
    task automatic core_access(input req_kind_t kind, input logic [31:0] addr,
                               input logic [31:0] wdata, input logic [3:0] be,
                               input logic hit, input logic miss);
        req_valid   <= 1'b1;
        req_kind    <= kind;
        req_addr    <= addr;
        req_wdata   <= wdata;
        req_be      <= be;
        expect_hit  <= hit;
        expect_miss <= miss;
        if (kind == REQ_READ) begin
            rd_addr <= addr;
        end
        do begin
            @(posedge clk);
        end while (!req_ready);
        req_valid <= 1'b0;
        if (kind == REQ_READ) begin
            do begin
                @(posedge clk);
            end while (!resp_valid);
        end
    endtask

    // Another agent changes memory, then the line is invalidated
    task automatic snoop_line(input logic [31:0] addr, input logic [31:0] new_word);
        do begin
            @(posedge clk);
        end while (!req_ready || mem_req_valid);
        mem_model[addr[9:2]] <= new_word;
        inv      <= 1'b1;
        inv_addr <= addr;
        @(posedge clk);
        inv <= 1'b0;
    endtask

    initial begin
        logic [31:0] addr;
        logic [31:0] data;
        seed = 32'hb9fc_20dd;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem_model[i] = $random(seed);
        end
        rst       = 1'b1;
        req_valid = 1'b0;
        req_kind  = REQ_READ;
        req_addr  = '0;
        req_wdata = '0;
        req_be    = '0;
        inv       = 1'b0;
        inv_addr  = '0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;

        // Line fill, then hits on every word of the line
        for (int i = 0; i < 12; i++) begin
            addr = rand_addr();
            core_access(REQ_READ, addr, '0, '0, 1'b0, 1'b0);
            for (int w = 0; w < `DCACHE_LINE_WORDS; w++) begin
                core_access(REQ_READ, {addr[31:LINE_LSB], word_sel_t'(w), 2'b00},
                            '0, '0, 1'b1, 1'b0);
            end
        end

        // Writes to cached and uncached lines with a read back of each
        for (int i = 0; i < 16; i++) begin
            addr = rand_addr();
            data = $random(seed);
            if (i % 2 == 0) begin
                core_access(REQ_READ, addr, '0, '0, 1'b0, 1'b0);
            end
            core_access(REQ_WRITE, addr, data, 4'($random(seed)), 1'b0, 1'b0);
            core_access(REQ_READ, addr, '0, '0, i % 2 == 0, 1'b0);
        end

        // Snoop of a cached line forces a refetch
        for (int i = 0; i < 8; i++) begin
            addr = rand_addr();
            core_access(REQ_READ, addr, '0, '0, 1'b0, 1'b0);
            core_access(REQ_READ, addr, '0, '0, 1'b1, 1'b0);
            snoop_line(addr, $random(seed));
            core_access(REQ_READ, addr, '0, '0, 1'b0, 1'b1);
        end

        // Random mix
        for (int i = 0; i < 120; i++) begin
            addr = rand_addr();
            data = $random(seed);
            case (2'($random(seed)))
                2'd0: core_access(REQ_WRITE, addr, data, 4'($random(seed)), 1'b0, 1'b0);
                2'd1: snoop_line(addr, data);
                default: core_access(REQ_READ, addr, '0, '0, 1'b0, 1'b0);
            endcase
        end

        // Wait until the last request has left the cache
        do begin
            @(posedge clk);
        end while (!req_ready || mem_req_valid || mem_rvalid);
        if (DUT.u_checker.error_count == 0) begin
            $display("ALL CHECKS PASSED");
            $finish;
        end else begin
            fail_run("an assertion in the checker failed");
        end
    end

endmodule

/* sim.f */
+incdir+verilog
verilog/dcache_pkg.sv
verilog/dcache_tagbank.sv
verilog/dcache_databank.sv
verilog/dcache_controller.sv
verilog/dcache_top.sv
sim/dcache_checker.sv
sim/dcache_tb.sv
